// File: logic/sched_pkg.sv
// shared widths, vector types and packed structs
// for the warp scheduler
`default_nettype none

package sched_pkg;

    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NUM_BARRIERS = 4;
    // byte addresses
    localparam int PC_W         = 32;

    localparam int WID_W = $clog2(NUM_WARPS);
    localparam int BAR_W = $clog2(NUM_BARRIERS);

    typedef logic [WID_W-1:0]       wid_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [PC_W-1:0]        pc_t;
    typedef logic [BAR_W-1:0]       bar_id_t;

    // execute stage control event, one kind per cycle
    typedef struct packed {
        logic    valid;
        wid_t    wid;
        logic    tmc_valid;
        tmask_t  tmc_mask;
        logic    spawn_valid;
        wmask_t  spawn_mask;
        pc_t     spawn_pc;
        logic    bar_valid;
        bar_id_t bar_id;
        // participating warps minus one
        wid_t    bar_size_m1;
    } warp_ctl_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    // per-warp update for the current cycle
    typedef struct packed {
        logic   unlock;
        logic   spawn;
        logic   set_tmask;
        tmask_t tmask;
        logic   set_pc;
        pc_t    pc;
    } slot_cmd_t;

    typedef struct packed {
        logic   active;
        logic   stalled;
        tmask_t tmask;
        pc_t    pc;
    } warp_state_t;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_out_t;

endpackage

`default_nettype wire

// File: logic/warp_ctl_router.sv
// event router: control, branch and unlock events to per-warp commands,
// plus local barrier counters and the pending spawn
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_router (
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire  sched_pkg::warp_ctl_t                   ctl,
    input  wire  sched_pkg::branch_t                     branch,
    input  wire                                          unlock_valid,
    input  wire  sched_pkg::wid_t                        unlock_wid,
    input  wire  sched_pkg::wmask_t                      active,
    output sched_pkg::slot_cmd_t [sched_pkg::NUM_WARPS-1:0] cmd
);
    import sched_pkg::*;

    // local barrier state
    wid_t   [NUM_BARRIERS-1:0] bar_ctr;
    wmask_t [NUM_BARRIERS-1:0] bar_mask;

    // pending spawn
    logic   spawn_pend;
    wmask_t spawn_mask;
    pc_t    spawn_pc;
    wid_t   spawn_wid;

    logic [WID_W:0] active_cnt;
    logic           single_warp;
    logic           spawn_fire;
    logic           bar_event;
    logic           bar_hit;

    always_comb begin
        active_cnt = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            active_cnt = active_cnt + (WID_W+1)'(active[i]);
        end
    end

    assign single_warp = (active_cnt == (WID_W+1)'(1));
    assign spawn_fire  = spawn_pend && single_warp;
    assign bar_event   = ctl.valid && ctl.bar_valid;
    assign bar_hit     = (bar_ctr[ctl.bar_id] == ctl.bar_size_m1);

    // later writes take priority within a slot
    always_comb begin
        cmd = '0;

        if (unlock_valid) begin
            cmd[unlock_wid].unlock = 1'b1;
        end

        if (spawn_fire) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (spawn_mask[i]) begin
                    cmd[i].spawn = 1'b1;
                    cmd[i].pc    = spawn_pc;
                end
            end
            cmd[spawn_wid].unlock = 1'b1;
        end

        if (ctl.valid && ctl.tmc_valid) begin
            cmd[ctl.wid].set_tmask = 1'b1;
            cmd[ctl.wid].tmask     = ctl.tmc_mask;
            cmd[ctl.wid].unlock    = 1'b1;
        end

        // last arrival frees every waiting warp and the caller
        if (bar_event && bar_hit) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (bar_mask[ctl.bar_id][i]) begin
                    cmd[i].unlock = 1'b1;
                end
            end
            cmd[ctl.wid].unlock = 1'b1;
        end

        if (branch.valid) begin
            cmd[branch.wid].unlock = 1'b1;
            if (branch.taken) begin
                cmd[branch.wid].set_pc = 1'b1;
                cmd[branch.wid].pc     = branch.dest;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_ctr    <= '0;
            bar_mask   <= '0;
            spawn_pend <= 1'b0;
        end else begin
            if (bar_event) begin
                if (bar_hit) begin
                    bar_ctr[ctl.bar_id]  <= '0;
                    bar_mask[ctl.bar_id] <= '0;
                end else begin
                    // caller stays stalled until release
                    bar_ctr[ctl.bar_id]           <= bar_ctr[ctl.bar_id] + wid_t'(1);
                    bar_mask[ctl.bar_id][ctl.wid] <= 1'b1;
                end
            end
            if (spawn_fire) begin
                spawn_pend <= 1'b0;
            end
            if (ctl.valid && ctl.spawn_valid) begin
                spawn_pend <= 1'b1;
            end
        end
    end

    // spawn payload
    always_ff @(posedge clk) begin
        if (ctl.valid && ctl.spawn_valid) begin
            spawn_mask <= ctl.spawn_mask;
            spawn_pc   <= ctl.spawn_pc;
            spawn_wid  <= ctl.wid;
        end
    end

endmodule

`default_nettype wire

// File: logic/warp_slot.sv
// state of one warp: active, stalled, thread mask and pc
`timescale 1ns/1ps
`default_nettype none

module warp_slot #(
    parameter int             WARP_ID  = 0,
    parameter sched_pkg::pc_t START_PC = '0
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire  sched_pkg::slot_cmd_t   cmd,
    input  wire                          grant,
    input  wire                          advance,
    output sched_pkg::warp_state_t       state
);
    import sched_pkg::*;

    warp_state_t state_nxt;
    warp_state_t state_rst;

    // only warp 0 runs out of reset
    always_comb begin
        state_rst = '0;
        if (WARP_ID == 0) begin
            state_rst.active = 1'b1;
            state_rst.tmask  = tmask_t'(1);
            state_rst.pc     = START_PC;
        end
    end

    // lowest precedence first, later assignments win
    always_comb begin
        state_nxt = state;

        if (cmd.unlock) begin
            state_nxt.stalled = 1'b0;
        end

        if (cmd.spawn) begin
            state_nxt.active  = 1'b1;
            state_nxt.stalled = 1'b0;
            state_nxt.tmask   = tmask_t'(1);
            state_nxt.pc      = cmd.pc;
        end

        // empty mask retires the warp
        if (cmd.set_tmask) begin
            state_nxt.active = |cmd.tmask;
            state_nxt.tmask  = cmd.tmask;
        end

        if (cmd.set_pc) begin
            state_nxt.pc = cmd.pc;
        end

        // held until decode unlocks it
        if (grant) begin
            state_nxt.stalled = 1'b1;
        end

        if (advance) begin
            state_nxt.pc = state.pc + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_rst;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// File: logic/warp_issue.sv
// lowest-index ready warp pick, registered valid/ready output, busy
`timescale 1ns/1ps
`default_nettype none

module warp_issue (
    input  wire                                                 clk,
    input  wire                                                 reset,
    input  wire  sched_pkg::warp_state_t [sched_pkg::NUM_WARPS-1:0] states,
    input  wire                                                 sched_ready,
    output sched_pkg::wmask_t                                   grant,
    output sched_pkg::wmask_t                                   advance,
    output logic                                                sched_valid,
    output sched_pkg::sched_out_t                               sched,
    output logic                                                busy
);
    import sched_pkg::*;

    wmask_t ready_vec;
    wmask_t active_vec;
    logic   pick_valid;
    wid_t   pick_wid;
    logic   out_free;
    logic   load_en;
    logic   fire;

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            active_vec[i] = states[i].active;
            ready_vec[i]  = states[i].active && !states[i].stalled;
        end
    end

    // scan down so the lowest ready index is kept
    always_comb begin
        pick_valid = 1'b0;
        pick_wid   = '0;
        for (int i = NUM_WARPS-1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                pick_valid = 1'b1;
                pick_wid   = wid_t'(i);
            end
        end
    end

    // register empty or draining this cycle
    assign fire     = sched_valid && sched_ready;
    assign out_free = !sched_valid || sched_ready;
    assign load_en  = pick_valid && out_free;

    assign grant   = load_en ? (wmask_t'(1) << pick_wid) : '0;
    assign advance = fire ? (wmask_t'(1) << sched.wid) : '0;
    assign busy    = |active_vec;

    always_ff @(posedge clk) begin
        if (reset) begin
            sched_valid <= 1'b0;
        end else if (out_free) begin
            sched_valid <= pick_valid;
        end
    end

    // output payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (load_en) begin
            sched.wid   <= pick_wid;
            sched.tmask <= states[pick_wid].tmask;
            sched.pc    <= states[pick_wid].pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/warp_scheduler.sv
// warp scheduler top: event router, per-warp slots and issue stage
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler #(
    parameter sched_pkg::pc_t START_PC = '0
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire  sched_pkg::warp_ctl_t   ctl,
    input  wire  sched_pkg::branch_t     branch,
    input  wire                          unlock_valid,
    input  wire  sched_pkg::wid_t        unlock_wid,
    input  wire                          sched_ready,
    output logic                         sched_valid,
    output sched_pkg::sched_out_t        sched,
    output logic                         busy
);
    import sched_pkg::*;

    slot_cmd_t   [NUM_WARPS-1:0] cmd;
    warp_state_t [NUM_WARPS-1:0] states;
    wmask_t                      active;
    wmask_t                      grant;
    wmask_t                      advance;

    // router judges spawn from the live active set
    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            active[i] = states[i].active;
        end
    end

    warp_ctl_router i_router (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .active       (active),
        .cmd          (cmd)
    );

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_slot
        warp_slot #(
            .WARP_ID  (w),
            .START_PC (START_PC)
        ) i_slot (
            .clk     (clk),
            .reset   (reset),
            .cmd     (cmd[w]),
            .grant   (grant[w]),
            .advance (advance[w]),
            .state   (states[w])
        );
    end

    warp_issue i_issue (
        .clk         (clk),
        .reset       (reset),
        .states      (states),
        .sched_ready (sched_ready),
        .grant       (grant),
        .advance     (advance),
        .sched_valid (sched_valid),
        .sched       (sched),
        .busy        (busy)
    );

endmodule

`default_nettype wire

// File: dv/warp_scheduler_assert.sv
// concurrent checks on the issue stage: output hold under back-pressure,
// one-hot grant that names the loaded warp, no grant to a stalled warp
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler_assert (
    input wire                                                  clk,
    input wire                                                  reset,
    input wire  sched_pkg::warp_state_t [sched_pkg::NUM_WARPS-1:0] states,
    input wire                                                  sched_ready,
    input wire  sched_pkg::wmask_t                              grant,
    input wire                                                  sched_valid,
    input wire  sched_pkg::sched_out_t                          sched
);
    import sched_pkg::*;

    wmask_t stalled_vec;

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            stalled_vec[i] = states[i].stalled;
        end
    end

    // payload held while the consumer is not ready
    property p_hold_stable;
        @(posedge clk) disable iff (reset)
            sched_valid && !sched_ready |=> sched_valid && $stable(sched);
    endproperty

    a_hold_stable: assert property (p_hold_stable)
        else $error("sched changed while held by sched_ready low");

    // a grant names exactly the warp shown in the next cycle
    property p_grant_loads;
        @(posedge clk) disable iff (reset)
            grant != '0 |=> sched_valid && ((wmask_t'(1) << sched.wid) == $past(grant));
    endproperty

    a_grant_onehot: assert property (p_grant_loads)
        else $error("grant is not one-hot or names a warp other than the loaded one");

    a_grant_unstalled: assert property (
        @(posedge clk) disable iff (reset) (grant & stalled_vec) == '0)
        else $error("grant given to a stalled warp");

endmodule

bind warp_issue warp_scheduler_assert i_assert (
    .clk         (clk),
    .reset       (reset),
    .states      (states),
    .sched_ready (sched_ready),
    .grant       (grant),
    .sched_valid (sched_valid),
    .sched       (sched)
);

`default_nettype wire

// File: dv/warp_scheduler_tb.sv
// testbench for the warp scheduler: event table, issue checks
// with random ready hold-off, per-row results and summary
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler_tb;
    import sched_pkg::*;

    localparam pc_t     START_PC    = 32'h0000_1000;
    localparam int      TIMEOUT     = 40;
    // all barrier rows use one barrier of two warps
    localparam bar_id_t BAR_ID      = 2'd1;
    localparam wid_t    BAR_SIZE_M1 = 2'd1;

    typedef enum logic [2:0] {
        EV_NONE, EV_UNLOCK, EV_BR_TAKEN, EV_BR_NOT, EV_TMC, EV_SPAWN, EV_BAR
    } ev_kind_t;

    typedef struct packed {
        ev_kind_t   kind;
        wid_t       wid;
        // tmc thread mask or spawn warp mask
        logic [3:0] mask;
        // branch dest or spawn pc
        pc_t        pc;
        // lfsr bits drawn for the ready hold-off
        logic [1:0] hold_bits;
        logic       exp_issue;
        wid_t       exp_wid;
        tmask_t     exp_tmask;
        pc_t        exp_pc;
        logic       exp_busy;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    warp_ctl_t   ctl;
    branch_t     branch;
    logic        unlock_valid;
    wid_t        unlock_wid;
    logic        sched_ready;
    logic        sched_valid;
    sched_out_t  sched;
    logic        busy;

    row_t        rows[$];
    logic [15:0] lfsr;
    int          errors;
    int          failed_rows;

    warp_scheduler #(
        .START_PC (START_PC)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .ctl          (ctl),
        .branch       (branch),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .sched_ready  (sched_ready),
        .sched_valid  (sched_valid),
        .sched        (sched),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_holdoff(input logic [1:0] nbits, output int cycles);
        cycles = 0;
        for (int i = 0; i < int'(nbits); i++) begin
            lfsr   = lfsr_next(lfsr);
            cycles = (cycles << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic clear_events();
        ctl          = '0;
        branch       = '0;
        unlock_valid = 1'b0;
        unlock_wid   = '0;
    endtask

    task automatic add_row(input ev_kind_t kind, input wid_t wid, input logic [3:0] mask,
                           input pc_t pc, input logic [1:0] hold_bits,
                           input logic exp_issue, input wid_t exp_wid,
                           input tmask_t exp_tmask, input pc_t exp_pc,
                           input logic exp_busy);
        row_t r;
        r.kind      = kind;
        r.wid       = wid;
        r.mask      = mask;
        r.pc        = pc;
        r.hold_bits = hold_bits;
        r.exp_issue = exp_issue;
        r.exp_wid   = exp_wid;
        r.exp_tmask = exp_tmask;
        r.exp_pc    = exp_pc;
        r.exp_busy  = exp_busy;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // first issue after reset, then no reissue without unlock
        add_row(EV_NONE,     2'd0, 4'h0, 32'h0,    2'd3, 1'b1, 2'd0, 4'h1, 32'h1000, 1'b1);
        add_row(EV_NONE,     2'd0, 4'h0, 32'h0,    2'd1, 1'b0, 2'd0, 4'h0, 32'h0,    1'b1);
        add_row(EV_UNLOCK,   2'd0, 4'h0, 32'h0,    2'd2, 1'b1, 2'd0, 4'h1, 32'h1004, 1'b1);
        // branches release the warp too
        add_row(EV_BR_TAKEN, 2'd0, 4'h0, 32'h3000, 2'd2, 1'b1, 2'd0, 4'h1, 32'h3000, 1'b1);
        add_row(EV_BR_NOT,   2'd0, 4'h0, 32'h0,    2'd3, 1'b1, 2'd0, 4'h1, 32'h3004, 1'b1);
        // spawn warps 1-3 while warp 0 runs alone
        add_row(EV_SPAWN,    2'd0, 4'hE, 32'h2000, 2'd2, 1'b1, 2'd0, 4'h1, 32'h3008, 1'b1);
        add_row(EV_NONE,     2'd0, 4'h0, 32'h0,    2'd1, 1'b1, 2'd1, 4'h1, 32'h2000, 1'b1);
        add_row(EV_NONE,     2'd0, 4'h0, 32'h0,    2'd3, 1'b1, 2'd2, 4'h1, 32'h2000, 1'b1);
        add_row(EV_NONE,     2'd0, 4'h0, 32'h0,    2'd2, 1'b1, 2'd3, 4'h1, 32'h2000, 1'b1);
        // warp 1 waits at the barrier, warp 3 goes ahead of it
        add_row(EV_BAR,      2'd1, 4'h0, 32'h0,    2'd1, 1'b0, 2'd0, 4'h0, 32'h0,    1'b1);
        add_row(EV_UNLOCK,   2'd3, 4'h0, 32'h0,    2'd2, 1'b1, 2'd3, 4'h1, 32'h2004, 1'b1);
        add_row(EV_BAR,      2'd2, 4'h0, 32'h0,    2'd3, 1'b1, 2'd1, 4'h1, 32'h2004, 1'b1);
        add_row(EV_NONE,     2'd0, 4'h0, 32'h0,    2'd1, 1'b1, 2'd2, 4'h1, 32'h2004, 1'b1);
        add_row(EV_TMC,      2'd1, 4'hB, 32'h0,    2'd2, 1'b1, 2'd1, 4'hB, 32'h2008, 1'b1);
        // empty masks retire every warp
        add_row(EV_TMC,      2'd0, 4'h0, 32'h0,    2'd1, 1'b0, 2'd0, 4'h0, 32'h0,    1'b1);
        add_row(EV_TMC,      2'd1, 4'h0, 32'h0,    2'd1, 1'b0, 2'd0, 4'h0, 32'h0,    1'b1);
        add_row(EV_TMC,      2'd2, 4'h0, 32'h0,    2'd1, 1'b0, 2'd0, 4'h0, 32'h0,    1'b1);
        add_row(EV_TMC,      2'd3, 4'h0, 32'h0,    2'd1, 1'b0, 2'd0, 4'h0, 32'h0,    1'b0);
    endtask

    // one-cycle event pulse
    task automatic apply_event(input row_t r);
        @(negedge clk);
        case (r.kind)
            EV_UNLOCK: begin
                unlock_valid = 1'b1;
                unlock_wid   = r.wid;
            end
            EV_BR_TAKEN, EV_BR_NOT: begin
                branch.valid = 1'b1;
                branch.wid   = r.wid;
                branch.taken = (r.kind == EV_BR_TAKEN);
                branch.dest  = r.pc;
            end
            EV_TMC: begin
                ctl.valid     = 1'b1;
                ctl.wid       = r.wid;
                ctl.tmc_valid = 1'b1;
                ctl.tmc_mask  = r.mask;
            end
            EV_SPAWN: begin
                ctl.valid       = 1'b1;
                ctl.wid         = r.wid;
                ctl.spawn_valid = 1'b1;
                ctl.spawn_mask  = r.mask;
                ctl.spawn_pc    = r.pc;
            end
            EV_BAR: begin
                ctl.valid       = 1'b1;
                ctl.wid         = r.wid;
                ctl.bar_valid   = 1'b1;
                ctl.bar_id      = BAR_ID;
                ctl.bar_size_m1 = BAR_SIZE_M1;
            end
            default: ;
        endcase
        @(negedge clk);
        clear_events();
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // holds ready low for a random time, then waits for one transfer
    task automatic wait_issue(input logic [1:0] hold_bits, output logic got,
                              output sched_out_t val);
        int         holdoff;
        int         n;
        logic       seen;
        sched_out_t held;
        got  = 1'b0;
        val  = '0;
        seen = 1'b0;
        held = '0;
        n    = 0;
        draw_holdoff(hold_bits, holdoff);
        while (!got && n < TIMEOUT) begin
            @(negedge clk);
            sched_ready = (n >= holdoff);
            if (seen) begin
                assert (sched == held) else begin
                    $display("CHECK FAILED sched: got %h expected %h", sched, held);
                    errors++;
                end
            end
            if (sched_valid && sched_ready) begin
                got = 1'b1;
                val = sched;
            end else if (sched_valid) begin
                seen = 1'b1;
                held = sched;
            end
            n++;
        end
        // transfer edge passes before ready drops
        @(negedge clk);
        sched_ready = 1'b0;
    endtask

    initial begin : main
        int         row_errors;
        logic       got;
        sched_out_t val;
        errors      = 0;
        failed_rows = 0;
        lfsr        = 16'd60653;
        reset       = 1'b1;
        sched_ready = 1'b0;
        clear_events();
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (rows[i]) begin
            row_errors = errors;
            apply_event(rows[i]);
            wait_issue(rows[i].hold_bits, got, val);
            if (rows[i].exp_issue) begin
                if (!got) begin
                    $display("row %0d: no issue within %0d cycles", i, TIMEOUT);
                    errors++;
                end else begin
                    check_field("sched.wid", 32'(val.wid), 32'(rows[i].exp_wid));
                    check_field("sched.tmask", 32'(val.tmask), 32'(rows[i].exp_tmask));
                    check_field("sched.pc", val.pc, rows[i].exp_pc);
                end
            end else begin
                assert (!got) else begin
                    $display("row %0d: warp %0d issued where none was expected", i, val.wid);
                    errors++;
                end
            end
            check_field("busy", 32'(busy), 32'(rows[i].exp_busy));
            if (errors != row_errors) begin
                failed_rows++;
                $display("row %0d: failed", i);
            end else begin
                $display("row %0d: ok", i);
            end
        end

        $display("rows run %0d, rows failed %0d, check errors %0d",
                 rows.size(), failed_rows, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
logic/sched_pkg.sv
logic/warp_ctl_router.sv
logic/warp_slot.sv
logic/warp_issue.sv
logic/warp_scheduler.sv
dv/warp_scheduler_assert.sv
dv/warp_scheduler_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the warp scheduler testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module warp_scheduler_tb \
    -f tb.f \
    -o warp_scheduler_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output="$(./obj_dir/warp_scheduler_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F "ALL TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
